// File: src/cart_pkg.sv
// Shared widths, header offsets and fill bytes for the cartridge loader
// Header offsets are byte addresses within the ROM image, before any copier header
`default_nettype none

package cart_pkg;

	// ====================
	// Download and header types
	typedef logic [24:0]  dl_addr_t;
	typedef logic [15:0]  dl_word_t;
	typedef logic [7:0]   dl_index_t;
	typedef logic [23:0]  mem_mask_t;
	typedef logic [7:0]   rom_type_t;
	typedef logic [3:0]   size_code_t;
	typedef logic [2:0]   header_mode_t;
	typedef logic [1:0]   region_mode_t;

	// ====================
	// Clear, cheat and backup types
	typedef logic [16:0]  fill_addr_t;
	typedef logic [1:0]   fill_pattern_t;
	typedef logic [127:0] cheat_code_t;
	typedef logic [31:0]  sector_t;
	typedef logic [63:0]  img_size_t;

	typedef enum logic [1:0] {
		BK_IDLE,
		BK_REQ,
		BK_ACK
	} bk_state_t;

	// Copier header in front of the image
	localparam dl_addr_t COPIER_HDR = 25'd512;

	// Size bytes in the internal header, one pair per mapping
	localparam dl_addr_t LOROM_SIZE_OFS = 25'h007FD6;
	localparam dl_addr_t LOROM_RAM_OFS  = 25'h007FD8;
	localparam dl_addr_t HIROM_SIZE_OFS = 25'h00FFD6;
	localparam dl_addr_t HIROM_RAM_OFS  = 25'h00FFD8;
	localparam dl_addr_t EXHI_SIZE_OFS  = 25'h40FFD6;
	localparam dl_addr_t EXHI_RAM_OFS   = 25'h40FFD8;

	localparam size_code_t DEFAULT_ROM_SIZE = 4'hC;
	localparam int         SECTOR_SHIFT     = 9;

	// Work RAM fill bytes
	localparam logic [7:0] FILL_66 = 8'h66;
	localparam logic [7:0] FILL_99 = 8'h99;
	localparam logic [7:0] FILL_FF = 8'hFF;
	localparam logic [7:0] FILL_00 = 8'h00;
	localparam logic [7:0] FILL_55 = 8'h55;

endpackage

`default_nettype wire

// File: src/cart_load_parser.sv
// Header size fields are taken from the word written at each offset; masks lag one write
// pal only tracks region settings while no cartridge is loading
`timescale 1ns/1ps
`default_nettype none

module cart_load_parser (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          dl_active,
	input  wire cart_pkg::dl_index_t     dl_index,
	input  wire                          dl_wr,
	input  wire cart_pkg::dl_addr_t      dl_addr,
	input  wire cart_pkg::dl_word_t      dl_data,
	input  wire cart_pkg::header_mode_t  header_mode,
	input  wire cart_pkg::region_mode_t  region_mode,
	output logic                         cart_loading,
	output logic                         code_loading,
	output logic                         load_start,
	output logic                         load_end,
	output cart_pkg::rom_type_t          rom_type,
	output cart_pkg::mem_mask_t          rom_mask,
	output cart_pkg::mem_mask_t          ram_mask,
	output logic                         pal
);

	logic                 code_index;
	logic                 cart_loading_q;
	logic                 cart_wr;
	logic                 hdr_fixed;
	logic                 rom_region;
	cart_pkg::size_code_t rom_size;
	cart_pkg::size_code_t ram_size;
	cart_pkg::dl_addr_t   size_ofs;
	cart_pkg::dl_addr_t   ram_ofs;

	// Index all ones carries cheat codes
	assign code_index   = &dl_index;
	assign cart_loading = dl_active & ~code_index;
	assign code_loading = dl_active & code_index;
	assign load_start   = cart_loading & ~cart_loading_q;
	assign load_end     = cart_loading_q & ~cart_loading;
	assign cart_wr      = cart_loading & dl_wr;

	// Header offsets for forced mappings, shifted past the copier header
	always_comb begin
		hdr_fixed = 1'b1;
		size_ofs  = '0;
		ram_ofs   = '0;
		case (header_mode)
			3'd2: begin
				size_ofs = cart_pkg::LOROM_SIZE_OFS + cart_pkg::COPIER_HDR;
				ram_ofs  = cart_pkg::LOROM_RAM_OFS + cart_pkg::COPIER_HDR;
			end
			3'd3: begin
				size_ofs = cart_pkg::HIROM_SIZE_OFS + cart_pkg::COPIER_HDR;
				ram_ofs  = cart_pkg::HIROM_RAM_OFS + cart_pkg::COPIER_HDR;
			end
			3'd4: begin
				size_ofs = cart_pkg::EXHI_SIZE_OFS + cart_pkg::COPIER_HDR;
				ram_ofs  = cart_pkg::EXHI_RAM_OFS + cart_pkg::COPIER_HDR;
			end
			default: hdr_fixed = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_loading_q <= 1'b0;
			rom_size       <= cart_pkg::DEFAULT_ROM_SIZE;
			ram_size       <= '0;
			rom_region     <= 1'b0;
			rom_type       <= '0;
			rom_mask       <= '0;
			ram_mask       <= '0;
			pal            <= 1'b0;
		end else begin
			cart_loading_q <= cart_loading;
			if (cart_wr) begin
				if (dl_addr == '0) begin
					rom_size <= cart_pkg::DEFAULT_ROM_SIZE;
					ram_size <= '0;
					// Auto mode: loader packs both size codes into the low byte
					if (header_mode == 3'd0 && dl_data[7:0] != 8'h00) begin
						ram_size <= dl_data[7:4];
						rom_size <= dl_data[3:0];
					end
					case (header_mode)
						3'd1, 3'd2: rom_type <= 8'd0;
						3'd3:       rom_type <= 8'd1;
						3'd4:       rom_type <= 8'd2;
						default:    rom_type <= dl_data[15:8];
					endcase
				end
				if (dl_addr == 25'd2)
					rom_region <= dl_data[8];
				if (hdr_fixed && dl_addr == size_ofs)
					rom_size <= dl_data[11:8];
				if (hdr_fixed && dl_addr == ram_ofs)
					ram_size <= dl_data[3:0];
				// Sizes are 1 KB shifted by the code
				rom_mask <= (cart_pkg::mem_mask_t'(1024) << rom_size) - 24'd1;
				ram_mask <= (ram_size != '0) ?
					(cart_pkg::mem_mask_t'(1024) << ram_size) - 24'd1 : '0;
			end
			if (!cart_loading)
				pal <= (region_mode == '0) ? rom_region : region_mode[1];
		end
	end

endmodule

`default_nettype wire

// File: src/cheat_code_assembler.sv
// Words land by address modulo 16; a partial code stays until overwritten
`timescale 1ns/1ps
`default_nettype none

module cheat_code_assembler (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     code_loading,
	input  wire                     cart_loading,
	input  wire                     dl_wr,
	input  wire cart_pkg::dl_addr_t dl_addr,
	input  wire cart_pkg::dl_word_t dl_data,
	output cart_pkg::cheat_code_t   cheat_code,
	output logic                    cheat_valid,
	output logic                    cheat_clear
);

	logic code_wr;
	logic clear_q;

	assign code_wr = code_loading & dl_wr;

	// Cheat list is flushed by a new cart or a fresh code file
	assign cheat_clear = clear_q | cart_loading;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			clear_q     <= 1'b0;
		end else begin
			cheat_valid <= code_wr && dl_addr[3:0] == 4'd14;
			clear_q     <= code_wr && dl_addr == '0;
		end
	end

	// Layout from the top: flags, address, compare, replace
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl_addr[3:0])
				4'd0:  cheat_code[111:96]  <= dl_data;
				4'd2:  cheat_code[127:112] <= dl_data;
				4'd4:  cheat_code[79:64]   <= dl_data;
				4'd6:  cheat_code[95:80]   <= dl_data;
				4'd8:  cheat_code[47:32]   <= dl_data;
				4'd10: cheat_code[63:48]   <= dl_data;
				4'd12: cheat_code[15:0]    <= dl_data;
				4'd14: cheat_code[31:16]   <= dl_data;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/ram_clear_fill.sv
// Sweeps all 128K work RAM addresses once per load; fill_data is valid only while active
`timescale 1ns/1ps
`default_nettype none

module ram_clear_fill (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          load_start,
	input  wire cart_pkg::fill_pattern_t fill_pattern,
	output logic                         fill_active,
	output cart_pkg::fill_addr_t         fill_addr,
	output logic [7:0]                   fill_data
);

	// ====================
	// Address sweep
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fill_active <= 1'b0;
			fill_addr   <= '0;
		end else begin
			if (load_start)
				fill_active <= 1'b1;
			else if (fill_active && &fill_addr)
				fill_active <= 1'b0;

			// Wraps back to 0 after the last address
			if (fill_active)
				fill_addr <= fill_addr + 17'd1;
			else
				fill_addr <= '0;
		end
	end

	// ====================
	// Power-on patterns of different console revisions
	always_comb begin
		case (fill_pattern)
			2'd0: begin
				fill_data = (fill_addr[8] ^ fill_addr[2]) ?
					cart_pkg::FILL_66 : cart_pkg::FILL_99;
			end
			2'd1: begin
				fill_data = (fill_addr[9] ^ fill_addr[0]) ?
					cart_pkg::FILL_FF : cart_pkg::FILL_00;
			end
			2'd2:    fill_data = cart_pkg::FILL_55;
			default: fill_data = cart_pkg::FILL_FF;
		endcase
	end

endmodule

`default_nettype wire

// File: src/backup_sector_seq.sv
// Moves backup RAM in 512-byte sectors; the SD side must pulse sd_ack once per sector
// Requests are ignored unless a writable image was mounted during the last cart load
`timescale 1ns/1ps
`default_nettype none

module backup_sector_seq (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire                       cart_loading,
	input  wire                       load_start,
	input  wire                       load_end,
	input  wire cart_pkg::mem_mask_t  ram_mask,
	input  wire                       img_mounted,
	input  wire                       img_readonly,
	input  wire cart_pkg::img_size_t  img_size,
	input  wire                       bk_load_req,
	input  wire                       bk_save_req,
	input  wire                       autosave,
	input  wire                       osd_open,
	input  wire                       bsram_write,
	input  wire                       sd_ack,
	output cart_pkg::sector_t         sd_lba,
	output logic                      sd_rd,
	output logic                      sd_wr,
	output logic                      bk_ena,
	output logic                      bk_pending,
	output logic                      bk_loading,
	output logic                      bk_busy
);

	cart_pkg::bk_state_t state;
	cart_pkg::sector_t   last_sector;
	logic                save_cond;
	logic                load_q;
	logic                save_q;
	logic                ack_q;
	logic                load_rise;
	logic                save_rise;
	logic                ack_rise;
	logic                ack_fall;
	logic                auto_load;

	// Autosave fires when the menu opens with unsaved changes
	assign save_cond   = bk_save_req | (bk_pending & osd_open & autosave);
	assign load_rise   = bk_load_req & ~load_q;
	assign save_rise   = save_cond & ~save_q;
	assign ack_rise    = sd_ack & ~ack_q;
	assign ack_fall    = ack_q & ~sd_ack;
	assign auto_load   = load_end & (img_size != '0);
	assign last_sector = cart_pkg::sector_t'(ram_mask >> cart_pkg::SECTOR_SHIFT);
	assign bk_busy     = state != cart_pkg::BK_IDLE;

	// ====================
	// Enable and pending flag
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			if (load_start)
				bk_ena <= 1'b0;
			else if (cart_loading && img_mounted && !img_readonly)
				bk_ena <= ram_mask != '0;

			// Writes while the menu is open are not counted
			if (bk_ena && !osd_open && bsram_write)
				bk_pending <= 1'b1;
			else if (bk_busy)
				bk_pending <= 1'b0;
		end
	end

	// ====================
	// Sector transfer FSM
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= cart_pkg::BK_IDLE;
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			ack_q      <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			load_q <= bk_load_req;
			save_q <= save_cond;
			ack_q  <= sd_ack;

			case (state)
				cart_pkg::BK_IDLE: begin
					if (bk_ena && (load_rise || save_rise || auto_load)) begin
						// Load wins over save when both arrive together
						state      <= cart_pkg::BK_REQ;
						bk_loading <= load_rise | auto_load;
						sd_lba     <= '0;
						sd_rd      <= load_rise | auto_load;
						sd_wr      <= ~(load_rise | auto_load);
					end
				end
				cart_pkg::BK_REQ: begin
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= cart_pkg::BK_ACK;
					end
				end
				cart_pkg::BK_ACK: begin
					if (ack_fall) begin
						if (sd_lba >= last_sector) begin
							state      <= cart_pkg::BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							state  <= cart_pkg::BK_REQ;
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
				default: state <= cart_pkg::BK_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/cart_loader_top.sv
// Loader control path only; memories and the SD buffer port live outside
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top (
	input  wire                          clk_sys,
	input  wire                          reset,
	// Download port
	input  wire                          dl_active,
	input  wire cart_pkg::dl_index_t     dl_index,
	input  wire                          dl_wr,
	input  wire cart_pkg::dl_addr_t      dl_addr,
	input  wire cart_pkg::dl_word_t      dl_data,
	// Menu settings
	input  wire cart_pkg::header_mode_t  header_mode,
	input  wire cart_pkg::region_mode_t  region_mode,
	input  wire cart_pkg::fill_pattern_t fill_pattern,
	input  wire                          bk_load_req,
	input  wire                          bk_save_req,
	input  wire                          autosave,
	input  wire                          osd_open,
	// Image and SD transfer
	input  wire                          img_mounted,
	input  wire                          img_readonly,
	input  wire cart_pkg::img_size_t     img_size,
	input  wire                          bsram_write,
	input  wire                          sd_ack,
	output cart_pkg::sector_t            sd_lba,
	output logic                         sd_rd,
	output logic                         sd_wr,
	// Cartridge configuration
	output logic                         cart_loading,
	output logic                         code_loading,
	output cart_pkg::rom_type_t          rom_type,
	output cart_pkg::mem_mask_t          rom_mask,
	output cart_pkg::mem_mask_t          ram_mask,
	output logic                         pal,
	// Cheats
	output cart_pkg::cheat_code_t        cheat_code,
	output logic                         cheat_valid,
	output logic                         cheat_clear,
	// Work RAM clear
	output logic                         fill_active,
	output cart_pkg::fill_addr_t         fill_addr,
	output logic [7:0]                   fill_data,
	// Backup status
	output logic                         bk_ena,
	output logic                         bk_pending,
	output logic                         bk_loading,
	output logic                         bk_busy
);

	logic load_start;
	logic load_end;

	cart_load_parser u_parser (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl_active),
		.dl_index     (dl_index),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.header_mode  (header_mode),
		.region_mode  (region_mode),
		.cart_loading (cart_loading),
		.code_loading (code_loading),
		.load_start   (load_start),
		.load_end     (load_end),
		.rom_type     (rom_type),
		.rom_mask     (rom_mask),
		.ram_mask     (ram_mask),
		.pal          (pal)
	);

	cheat_code_assembler u_cheat (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.code_loading (code_loading),
		.cart_loading (cart_loading),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.cheat_code   (cheat_code),
		.cheat_valid  (cheat_valid),
		.cheat_clear  (cheat_clear)
	);

	ram_clear_fill u_fill (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.load_start   (load_start),
		.fill_pattern (fill_pattern),
		.fill_active  (fill_active),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data)
	);

	backup_sector_seq u_backup (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_loading (cart_loading),
		.load_start   (load_start),
		.load_end     (load_end),
		.ram_mask     (ram_mask),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.autosave     (autosave),
		.osd_open     (osd_open),
		.bsram_write  (bsram_write),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_ena       (bk_ena),
		.bk_pending   (bk_pending),
		.bk_loading   (bk_loading),
		.bk_busy      (bk_busy)
	);

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// Free-running testbench clock, starts low, 8 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys
);

	initial clk_sys = 1'b0;

	// Half period
	always #4 clk_sys = ~clk_sys;

endmodule

`default_nettype wire

// File: tb/cart_loader_sva.sv
// Bound into cart_loader_top; rules are not checked while reset is high
`timescale 1ns/1ps
`default_nettype none

module cart_loader_sva (
	input wire clk_sys,
	input wire reset,
	input wire sd_rd,
	input wire sd_wr,
	input wire sd_ack,
	input wire cheat_valid
);

	// Failure total, read by the testbench summary
	int unsigned fail_count = 0;

	// ====================
	// SD request rules
	rd_wr_exclusive: assert property (
		@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr)
	) else begin
		fail_count++;
		$error("sd_rd and sd_wr are high together");
	end

	// Request drops on the cycle after the acknowledge is seen
	req_drops_after_ack: assert property (
		@(posedge clk_sys) disable iff (reset) $rose(sd_ack) |-> ##[1:2] !(sd_rd || sd_wr)
	) else begin
		fail_count++;
		$error("SD request still high two cycles after sd_ack rose");
	end

	// ====================
	// Cheat strobe
	cheat_valid_one_cycle: assert property (
		@(posedge clk_sys) disable iff (reset) cheat_valid |=> !cheat_valid
	) else begin
		fail_count++;
		$error("cheat_valid high for more than one cycle");
	end

endmodule

`default_nettype wire

// File: tb/cart_loader_tb.sv
// Directed tests for the cartridge loader control path; run time is bounded by two RAM sweeps
// SD acknowledge comes from an inline responder with random delays from a fixed seed
`timescale 1ns/1ps
`default_nettype none

module cart_loader_tb;

	// Two sweeps of 131072 cycles plus the short tests and some margin
	localparam int MAX_CYCLES = 400000;

	logic                    clk_sys;
	logic                    reset;
	logic                    dl_active;
	cart_pkg::dl_index_t     dl_index;
	logic                    dl_wr;
	cart_pkg::dl_addr_t      dl_addr;
	cart_pkg::dl_word_t      dl_data;
	cart_pkg::header_mode_t  header_mode;
	cart_pkg::region_mode_t  region_mode;
	cart_pkg::fill_pattern_t fill_pattern;
	logic                    bk_load_req;
	logic                    bk_save_req;
	logic                    autosave;
	logic                    osd_open;
	logic                    img_mounted;
	logic                    img_readonly;
	cart_pkg::img_size_t     img_size;
	logic                    bsram_write;
	logic                    sd_ack;
	cart_pkg::sector_t       sd_lba;
	logic                    sd_rd;
	logic                    sd_wr;
	logic                    cart_loading;
	logic                    code_loading;
	cart_pkg::rom_type_t     rom_type;
	cart_pkg::mem_mask_t     rom_mask;
	cart_pkg::mem_mask_t     ram_mask;
	logic                    pal;
	cart_pkg::cheat_code_t   cheat_code;
	logic                    cheat_valid;
	logic                    cheat_clear;
	logic                    fill_active;
	cart_pkg::fill_addr_t    fill_addr;
	logic [7:0]              fill_data;
	logic                    bk_ena;
	logic                    bk_pending;
	logic                    bk_loading;
	logic                    bk_busy;

	int checks = 0;
	int errors = 0;
	int cycle_count = 0;

	tb_clock_gen u_clk (.clk_sys(clk_sys));

	cart_loader_top uut (.*);

	bind cart_loader_top cart_loader_sva u_sva (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.sd_rd       (sd_rd),
		.sd_wr       (sd_wr),
		.sd_ack      (sd_ack),
		.cheat_valid (cheat_valid)
	);

	// ====================
	// Checking and reporting
	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	task automatic print_summary;
		$display("Checks: %0d, check errors: %0d, assertion errors: %0d",
			checks, errors, uut.u_sva.fail_count);
	endtask

	// Mask for a size of 1 KB shifted left by the code
	function automatic cart_pkg::mem_mask_t size_mask(input cart_pkg::size_code_t code);
		logic [31:0] bytes;
		bytes = 32'd1024 << code;
		return cart_pkg::mem_mask_t'(bytes - 32'd1);
	endfunction

	function automatic int sectors_for(input cart_pkg::mem_mask_t mask);
		return int'(mask >> cart_pkg::SECTOR_SHIFT) + 1;
	endfunction

	function automatic logic [7:0] pattern_byte(input cart_pkg::fill_pattern_t pattern,
		input cart_pkg::fill_addr_t addr);
		case (pattern)
			2'd0: return (addr[8] != addr[2]) ? 8'h66 : 8'h99;
			2'd1: return (addr[9] != addr[0]) ? 8'hFF : 8'h00;
			2'd2: return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	// ====================
	// Download and SD helpers
	task automatic next_cycle;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic begin_download(input cart_pkg::dl_index_t index);
		dl_index  = index;
		dl_active = 1'b1;
		next_cycle();
	endtask

	task automatic end_download;
		dl_active = 1'b0;
		next_cycle();
	endtask

	task automatic write_word(input cart_pkg::dl_addr_t addr, input cart_pkg::dl_word_t data);
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		next_cycle();
		dl_wr   = 1'b0;
	endtask

	task automatic wait_request(output logic found);
		int waited;
		waited = 0;
		found  = 1'b0;
		while (!found && waited < 100) begin
			if (sd_rd || sd_wr)
				found = 1'b1;
			else begin
				next_cycle();
				waited++;
			end
		end
	endtask

	task automatic respond_ack;
		repeat (1 + $urandom % 3) next_cycle();
		sd_ack = 1'b1;
		repeat (2 + $urandom % 4) next_cycle();
		sd_ack = 1'b0;
		next_cycle();
	endtask

	task automatic wait_idle;
		int waited;
		waited = 0;
		while (bk_busy && waited < 100) begin
			next_cycle();
			waited++;
		end
		assert (!bk_busy) else report_failure("bk_busy stayed high after the last sector");
	endtask

	// Serves count sectors in order and then watches for stray requests
	task automatic serve_transfer(input logic is_read, input int count);
		logic found;
		logic extra;
		int i;
		extra = 1'b0;
		for (i = 0; i < count; i++) begin
			wait_request(found);
			assert (found) else report_failure($sformatf("no SD request for sector %0d", i));
			if (!found)
				return;
			check_value("sd_rd", sd_rd, is_read);
			check_value("sd_wr", sd_wr, !is_read);
			check_value("sd_lba", sd_lba, i);
			check_value("bk_loading", bk_loading, is_read);
			check_value("bk_busy", bk_busy, 1'b1);
			respond_ack();
		end
		wait_idle();
		repeat (10) begin
			if (sd_rd || sd_wr)
				extra = 1'b1;
			next_cycle();
		end
		check_value("extra SD request", extra, 1'b0);
		check_value("bk_loading", bk_loading, 1'b0);
	endtask

	// ====================
	// Tests
	task automatic check_reset_values;
		check_value("cheat_valid", cheat_valid, 1'b0);
		check_value("cheat_clear", cheat_clear, 1'b0);
		check_value("fill_active", fill_active, 1'b0);
		check_value("sd_rd", sd_rd, 1'b0);
		check_value("sd_wr", sd_wr, 1'b0);
		check_value("bk_busy", bk_busy, 1'b0);
		check_value("bk_loading", bk_loading, 1'b0);
		check_value("bk_ena", bk_ena, 1'b0);
		check_value("bk_pending", bk_pending, 1'b0);
	endtask

	task automatic parse_auto_header;
		cart_pkg::dl_word_t   word0;
		cart_pkg::dl_word_t   word2;
		cart_pkg::size_code_t rom_code;
		cart_pkg::size_code_t ram_code;
		word0 = 16'($urandom);
		if (word0[7:0] == 8'h00)
			word0[0] = 1'b1;
		word2    = 16'($urandom);
		word2[8] = 1'b1;
		rom_code = word0[3:0];
		ram_code = word0[7:4];
		header_mode = 3'd0;
		region_mode = 2'd0;
		begin_download(8'h00);
		check_value("cart_loading", cart_loading, 1'b1);
		check_value("code_loading", code_loading, 1'b0);
		// Cheat list stays cleared while a cart loads
		check_value("cheat_clear", cheat_clear, 1'b1);
		write_word(25'd0, word0);
		write_word(25'd2, word2);
		write_word(25'd4, 16'($urandom));
		end_download();
		check_value("cart_loading", cart_loading, 1'b0);
		next_cycle();
		check_value("cheat_clear", cheat_clear, 1'b0);
		check_value("rom_type", rom_type, word0[15:8]);
		check_value("rom_mask", rom_mask, size_mask(rom_code));
		check_value("ram_mask", ram_mask, (ram_code == 4'd0) ? 24'd0 : size_mask(ram_code));
		check_value("pal", pal, 1'b1);
		region_mode = 2'd1;
		next_cycle();
		check_value("pal", pal, 1'b0);
	endtask

	task automatic parse_lorom_header;
		cart_pkg::dl_word_t   size_word;
		cart_pkg::dl_word_t   ram_word;
		cart_pkg::dl_word_t   word2;
		cart_pkg::size_code_t rom_code;
		cart_pkg::size_code_t ram_code;
		rom_code  = 4'($urandom);
		ram_code  = 4'($urandom);
		size_word = 16'($urandom);
		size_word[11:8] = rom_code;
		ram_word  = 16'($urandom);
		ram_word[3:0] = ram_code;
		// Cart region bit clear so that pal must come from region_mode
		word2     = 16'($urandom);
		word2[8]  = 1'b0;
		header_mode = 3'd2;
		region_mode = 2'd2;
		begin_download(8'h00);
		write_word(25'd0, 16'($urandom));
		write_word(25'd2, word2);
		write_word(cart_pkg::LOROM_SIZE_OFS + cart_pkg::COPIER_HDR, size_word);
		write_word(cart_pkg::LOROM_RAM_OFS + cart_pkg::COPIER_HDR, ram_word);
		write_word(cart_pkg::LOROM_RAM_OFS + cart_pkg::COPIER_HDR + 25'd2, 16'($urandom));
		end_download();
		next_cycle();
		check_value("rom_type", rom_type, 8'd0);
		check_value("rom_mask", rom_mask, size_mask(rom_code));
		check_value("ram_mask", ram_mask, (ram_code == 4'd0) ? 24'd0 : size_mask(ram_code));
		check_value("pal", pal, 1'b1);
	endtask

	task automatic assemble_cheat;
		cart_pkg::dl_word_t    words [8];
		cart_pkg::cheat_code_t expect_code;
		int i;
		for (i = 0; i < 8; i++)
			words[i] = 16'($urandom);
		begin_download(8'hFF);
		check_value("code_loading", code_loading, 1'b1);
		check_value("cart_loading", cart_loading, 1'b0);
		for (i = 0; i < 8; i++) begin
			write_word(cart_pkg::dl_addr_t'(2 * i), words[i]);
			check_value("cheat_valid", cheat_valid, i == 7);
			if (i < 2)
				check_value("cheat_clear", cheat_clear, i == 0);
		end
		next_cycle();
		check_value("cheat_valid", cheat_valid, 1'b0);
		// Flags, address, compare, replace; low word at the lower offset
		expect_code = {words[1], words[0], words[3], words[2],
			words[5], words[4], words[7], words[6]};
		check_value("cheat_code", cheat_code, expect_code);
		end_download();
	endtask

	task automatic sweep_work_ram;
		int count;
		count = 0;
		while (fill_active && count < 140000) begin
			next_cycle();
			count++;
		end
		assert (!fill_active) else report_failure("earlier fill sweep never finished");
		fill_pattern = 2'($urandom);
		begin_download(8'h00);
		check_value("fill_active", fill_active, 1'b1);
		count = 0;
		while (fill_active && count < 140000) begin
			if (count == 4)
				dl_active = 1'b0;
			// Sampled blocks keep bits 0 to 2 moving while bits 8 and 9 sweep
			if (count[5:3] == 3'd0) begin
				check_value("fill_addr", fill_addr, count);
				check_value("fill_data", fill_data, pattern_byte(fill_pattern, 17'(count)));
			end
			next_cycle();
			count++;
		end
		check_value("fill_active cycles", count, 131072);
	endtask

	task automatic autoload_backup;
		img_mounted  = 1'b1;
		img_readonly = 1'b0;
		img_size     = 64'd8192;
		header_mode  = 3'd0;
		begin_download(8'h00);
		// Low byte 18 gives RAM code 1 and ROM code 8
		write_word(25'd0, {8'($urandom), 8'h18});
		write_word(25'd2, 16'($urandom));
		write_word(25'd4, 16'($urandom));
		check_value("ram_mask", ram_mask, size_mask(4'd1));
		check_value("bk_ena", bk_ena, 1'b1);
		end_download();
		serve_transfer(1'b1, sectors_for(size_mask(4'd1)));
	endtask

	task automatic save_backup;
		autosave = 1'b0;
		osd_open = 1'b1;
		bsram_write = 1'b1;
		next_cycle();
		bsram_write = 1'b0;
		next_cycle();
		check_value("bk_pending", bk_pending, 1'b0);
		osd_open = 1'b0;
		bsram_write = 1'b1;
		next_cycle();
		bsram_write = 1'b0;
		check_value("bk_pending", bk_pending, 1'b1);
		// Opening the menu with autosave on flushes the pending data
		autosave = 1'b1;
		osd_open = 1'b1;
		serve_transfer(1'b0, sectors_for(size_mask(4'd1)));
		check_value("bk_pending", bk_pending, 1'b0);
		autosave = 1'b0;
		osd_open = 1'b0;
		next_cycle();
		bk_save_req = 1'b1;
		serve_transfer(1'b0, sectors_for(size_mask(4'd1)));
		bk_save_req = 1'b0;
		next_cycle();
	endtask

	// ====================
	// Run limit
	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Cycle limit of %0d reached before the tests finished", MAX_CYCLES);
			print_summary();
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'hcc763b18));
		reset        = 1'b1;
		dl_active    = 1'b0;
		dl_index     = '0;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		header_mode  = '0;
		region_mode  = '0;
		fill_pattern = '0;
		bk_load_req  = 1'b0;
		bk_save_req  = 1'b0;
		autosave     = 1'b0;
		osd_open     = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = '0;
		bsram_write  = 1'b0;
		sd_ack       = 1'b0;
		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		check_reset_values();
		parse_auto_header();
		parse_lorom_header();
		assemble_cheat();
		sweep_work_ram();
		autoload_backup();
		save_backup();
		print_summary();
		if (errors == 0 && uut.u_sva.fail_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
src/cart_pkg.sv
src/cart_load_parser.sv
src/cheat_code_assembler.sv
src/ram_clear_fill.sv
src/backup_sector_seq.sv
src/cart_loader_top.sv
tb/tb_clock_gen.sv
tb/cart_loader_sva.sv
tb/cart_loader_tb.sv
